//--- hw/gb_bus_pkg.sv
package gb_bus_pkg;

	localparam int ADR_W   = 16;
	localparam int DATA_W  = 8;
	localparam int VRAM_AW = 13;
	localparam int OAM_AW  = 8;

	// value seen on an undriven data bus (pull-ups).
	localparam logic [DATA_W-1:0] OPEN_BUS = 8'hff;

	typedef struct packed {
		logic [7:0] page;
		logic [7:0] offset;
	} cpu_adr_split_t;

	// the memory map looks at the whole word, the I/O map only at the low byte.
	typedef union packed {
		logic [ADR_W-1:0] full;
		cpu_adr_split_t   split;
	} cpu_adr_u;

	typedef struct packed {
		cpu_adr_u          adr;
		logic              rd;
		logic              wr;
		logic [DATA_W-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic              active;
		logic [ADR_W-1:0]  src;
		logic [OAM_AW-1:0] dst;
		logic              rd;
		logic              wr;
		logic [DATA_W-1:0] data;
	} dma_req_t;

	typedef struct packed {
		logic [ADR_W-1:0] adr;
		logic             rd;
		logic             needs_vram;
		logic             needs_oam;
	} ppu_req_t;

	typedef struct packed {
		logic boot;
		logic rom;
		logic vram;
		logic xram;
		logic wram;
		logic oam;
		logic io;
	} region_t;

	typedef struct packed {
		logic joypad;
		logic serial;
		logic timer;
		logic int_flag;
		logic sound;
		logic ppu;
		logic boot_reg;
		logic hram;
		logic int_ena;
	} io_sel_t;

	typedef struct packed {
		logic [DATA_W-1:0] hram;
		logic [DATA_W-1:0] joy;
		logic [DATA_W-1:0] sio;
		logic [DATA_W-1:0] tim;
		logic [DATA_W-1:0] snd;
		logic [DATA_W-1:0] ppu;
		logic [DATA_W-1:0] cpureg;
		logic [DATA_W-1:0] brom;
		logic [DATA_W-1:0] vram;
		logic [DATA_W-1:0] oam;
		logic [DATA_W-1:0] ext;
	} periph_rdata_t;

	typedef struct packed {
		logic [VRAM_AW-1:0] adr;
		logic               rd;
		logic               wr;
		logic [DATA_W-1:0]  wdata;
	} vram_port_t;

	typedef struct packed {
		logic [OAM_AW-1:0] adr;
		logic              rd;
		logic              wr;
		logic [DATA_W-1:0] wdata;
	} oam_port_t;

	typedef struct packed {
		logic [ADR_W-1:0]  adr;
		logic              rd;
		logic              wr;
		logic [DATA_W-1:0] wdata;
		logic              cs_rom;
		logic              cs_xram;
		logic              cs_wram;
	} ext_port_t;

endpackage

//--- hw/gb_memmap.sv
`timescale 1ns/1ns

module gb_memmap #(
	parameter bit BOOT_OVERLAY = 1'b0
) (
	input  gb_bus_pkg::cpu_adr_u adr,
	input  logic                 boot_hidden,
	output gb_bus_pkg::region_t  region
);

	logic [gb_bus_pkg::ADR_W-1:0] a;

	assign a = adr.full;

	always_comb begin
		region = '0;
		if (!a[15]) begin
			// the boot ROM overlays the first page until software hides it.
			if (BOOT_OVERLAY && !boot_hidden && a[15:8] == 8'h00)
				region.boot = 1'b1;
			else
				region.rom = 1'b1;
		end else if (a[14:13] == 2'b00) begin
			region.vram = 1'b1;
		end else if (a[14:13] == 2'b01) begin
			region.xram = 1'b1;
		end else if (a < 16'hfe00) begin
			// echo RAM at E000-FDFF maps back onto WRAM.
			region.wram = 1'b1;
		end else if (a < 16'hfea0) begin
			region.oam = 1'b1;
		end else if (a >= 16'hff00) begin
			region.io = 1'b1;
		end
	end

endmodule

//--- hw/gb_iomap.sv
`timescale 1ns/1ns

module gb_iomap (
	input  gb_bus_pkg::cpu_adr_u adr,
	input  logic                 in_io,
	output gb_bus_pkg::io_sel_t  io_sel
);

	logic [7:0] ofs;

	assign ofs = adr.split.offset;

	always_comb begin
		io_sel = '0;
		if (in_io) begin
			case (ofs) inside
				8'h00:          io_sel.joypad   = 1'b1;
				[8'h01:8'h02]:  io_sel.serial   = 1'b1;
				[8'h04:8'h07]:  io_sel.timer    = 1'b1;
				8'h0f:          io_sel.int_flag = 1'b1;
				[8'h10:8'h3f]:  io_sel.sound    = 1'b1;
				[8'h40:8'h4b]:  io_sel.ppu      = 1'b1;
				8'h50:          io_sel.boot_reg = 1'b1;
				[8'h80:8'hfe]:  io_sel.hram     = 1'b1;
				8'hff:          io_sel.int_ena  = 1'b1;
				// unmapped holes select nothing.
				default: ;
			endcase
		end
	end

endmodule

//--- hw/gb_mem_arbiter.sv
`timescale 1ns/1ns

module gb_mem_arbiter (
	input  logic                    gbclk,
	input  logic                    rst_n,
	input  logic                    reset_done,
	input  gb_bus_pkg::cpu_req_t    cpu,
	input  gb_bus_pkg::dma_req_t    dma,
	input  gb_bus_pkg::ppu_req_t    ppu,
	input  gb_bus_pkg::region_t     cpu_region,
	input  gb_bus_pkg::region_t     dma_region,
	output gb_bus_pkg::vram_port_t  vram,
	output gb_bus_pkg::oam_port_t   oam,
	output gb_bus_pkg::ext_port_t   ext,
	output logic                    ext_oe
);

	logic dma_ext;
	logic wr_q;

	assign dma_ext = dma.active && (dma_region.rom || dma_region.xram || dma_region.wram);

	// the PPU owns VRAM during its fetch windows, then DMA, then the CPU.
	always_comb begin
		vram = '0;
		if (ppu.needs_vram) begin
			vram.adr = ppu.adr[gb_bus_pkg::VRAM_AW-1:0];
			vram.rd  = ppu.rd;
		end else if (dma.active && dma_region.vram) begin
			vram.adr = dma.src[gb_bus_pkg::VRAM_AW-1:0];
			vram.rd  = dma.rd;
		end else if (cpu_region.vram) begin
			vram.adr   = cpu.adr.full[gb_bus_pkg::VRAM_AW-1:0];
			vram.rd    = cpu.rd;
			vram.wr    = cpu.wr;
			vram.wdata = cpu.wdata;
		end
	end

	always_comb begin
		oam = '0;
		if (ppu.needs_oam) begin
			oam.adr = ppu.adr[gb_bus_pkg::OAM_AW-1:0];
			oam.rd  = ppu.rd;
		end else if (dma.active) begin
			// an active DMA always writes its destination slot.
			oam.adr   = dma.dst;
			oam.wr    = dma.wr;
			oam.wdata = dma.data;
		end else if (cpu_region.oam) begin
			oam.adr   = cpu.adr.full[gb_bus_pkg::OAM_AW-1:0];
			oam.rd    = cpu.rd;
			oam.wr    = cpu.wr;
			oam.wdata = cpu.wdata;
		end
	end

	always_comb begin
		ext.wdata   = cpu.wdata;
		ext.cs_rom  = cpu_region.rom || dma_region.rom;
		ext.cs_xram = cpu_region.xram || dma_region.xram;
		ext.cs_wram = cpu_region.wram || dma_region.wram;
		if (dma_ext) begin
			ext.adr = dma.src;
			ext.rd  = dma.rd;
			ext.wr  = 1'b0;
		end else begin
			ext.adr = cpu.adr.full;
			ext.rd  = cpu.rd;
			ext.wr  = cpu.wr;
		end
	end

	// keep the data pins driven one cycle past the write for hold time.
	always_ff @(posedge gbclk) begin
		if (!rst_n)
			wr_q <= 1'b0;
		else
			wr_q <= ext.wr;
	end

	assign ext_oe = reset_done && (ext.wr || wr_q);

endmodule

//--- hw/gb_read_mux.sv
`timescale 1ns/1ns

module gb_read_mux (
	input  gb_bus_pkg::region_t       cpu_region,
	input  gb_bus_pkg::region_t       dma_region,
	input  gb_bus_pkg::io_sel_t       io_sel,
	input  gb_bus_pkg::dma_req_t      dma,
	input  gb_bus_pkg::ppu_req_t      ppu,
	input  gb_bus_pkg::periph_rdata_t rdata,
	output logic [gb_bus_pkg::DATA_W-1:0] cpu_rdata,
	output logic [gb_bus_pkg::DATA_W-1:0] dma_rdata
);

	logic cpu_ext;
	logic dma_ext;
	logic dma_vram;

	assign cpu_ext  = cpu_region.rom || cpu_region.xram || cpu_region.wram;
	assign dma_ext  = dma_region.rom || dma_region.xram || dma_region.wram;
	assign dma_vram = dma.active && dma_region.vram;

	// a memory that another master holds this cycle reads as open bus.
	always_comb begin
		if (io_sel.hram)
			cpu_rdata = rdata.hram;
		else if (io_sel.joypad)
			cpu_rdata = rdata.joy;
		else if (io_sel.serial)
			cpu_rdata = rdata.sio;
		else if (io_sel.timer)
			cpu_rdata = rdata.tim;
		else if (io_sel.sound)
			cpu_rdata = rdata.snd;
		else if (io_sel.ppu)
			cpu_rdata = rdata.ppu;
		else if (io_sel.int_flag || io_sel.int_ena)
			cpu_rdata = rdata.cpureg;
		else if (cpu_region.boot)
			cpu_rdata = rdata.brom;
		else if (cpu_region.vram && !dma_vram && !ppu.needs_vram)
			cpu_rdata = rdata.vram;
		else if (cpu_region.oam && !dma.active && !ppu.needs_oam)
			cpu_rdata = rdata.oam;
		else if (cpu_ext && !(dma.active && dma_ext))
			cpu_rdata = rdata.ext;
		else
			cpu_rdata = gb_bus_pkg::OPEN_BUS;
	end

	always_comb begin
		if (dma_region.vram && !ppu.needs_vram)
			dma_rdata = rdata.vram;
		else if (dma_ext)
			dma_rdata = rdata.ext;
		else
			dma_rdata = gb_bus_pkg::OPEN_BUS;
	end

endmodule

//--- hw/gb_reset_seq.sv
`timescale 1ns/1ns

module gb_reset_seq #(
	parameter int INIT_TICK_W = 4,
	parameter int RST_TICK_W  = 4
) (
	input  logic gbclk,
	input  logic rst_n,
	input  logic gb_on,
	input  logic cart_mode,
	input  logic cart_rst_in,
	output logic reset_done,
	output logic reset_gb,
	output logic cart_rst_drive
);

	localparam logic [1:0] ST_ASSERT  = 2'd0;
	localparam logic [1:0] ST_RELEASE = 2'd1;
	localparam logic [1:0] ST_DONE    = 2'd2;

	logic [1:0]             state, state_n;
	logic [RST_TICK_W-1:0]  cnt, cnt_n;
	logic [INIT_TICK_W-1:0] init_cnt;
	logic                   init_done, init_done_n;
	logic                   gb_on_q;
	logic                   enter;

	always_comb begin
		init_done_n = init_done || (&init_cnt);
		// a power toggle or a reset from the cartridge restarts the sequence.
		enter   = (gb_on_q != gb_on) || (state == ST_DONE && cart_mode && !cart_rst_in);
		state_n = state;
		cnt_n   = cnt;
		if (init_done) begin
			if (enter) begin
				state_n = ST_ASSERT;
				cnt_n   = '0;
			end else begin
				case (state)
					ST_ASSERT: begin
						if (&cnt) begin
							state_n = ST_RELEASE;
							cnt_n   = '0;
						end else begin
							cnt_n = cnt + 1'b1;
						end
					end
					ST_RELEASE: begin
						// the cartridge may stretch the release phase by holding its pin low.
						if (gb_on && cart_mode && !cart_rst_in)
							cnt_n = '0;
						else if (&cnt)
							state_n = ST_DONE;
						else
							cnt_n = cnt + 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			init_cnt       <= '0;
			init_done      <= 1'b0;
			state          <= ST_ASSERT;
			cnt            <= '0;
			gb_on_q        <= 1'b0;
			reset_done     <= 1'b0;
			reset_gb       <= 1'b1;
			cart_rst_drive <= 1'b0;
		end else begin
			if (!init_done)
				init_cnt <= init_cnt + 1'b1;
			init_done      <= init_done_n;
			state          <= state_n;
			cnt            <= cnt_n;
			gb_on_q        <= gb_on;
			reset_done     <= state_n == ST_DONE;
			reset_gb       <= state_n != ST_DONE || !gb_on;
			cart_rst_drive <= init_done_n && gb_on && cart_mode && state_n != ST_ASSERT;
		end
	end

endmodule

//--- hw/gb_bus_top.sv
`timescale 1ns/1ns

module gb_bus_top #(
	parameter int INIT_TICK_W = 4,
	parameter int RST_TICK_W  = 4
) (
	input  logic                          gbclk,
	input  logic                          rst_n,
	input  gb_bus_pkg::cpu_req_t          cpu,
	input  gb_bus_pkg::dma_req_t          dma,
	input  gb_bus_pkg::ppu_req_t          ppu,
	input  gb_bus_pkg::periph_rdata_t     rdata,
	input  logic                          boot_hidden,
	input  logic                          gb_on,
	input  logic                          cart_mode,
	input  logic                          cart_rst_in,
	output gb_bus_pkg::vram_port_t        vram,
	output gb_bus_pkg::oam_port_t         oam,
	output gb_bus_pkg::ext_port_t         ext,
	output logic                          ext_oe,
	output gb_bus_pkg::io_sel_t           io_sel,
	output logic [gb_bus_pkg::DATA_W-1:0] cpu_rdata,
	output logic [gb_bus_pkg::DATA_W-1:0] dma_rdata,
	output logic                          reset_gb,
	output logic                          reset_done,
	output logic                          cart_rst_drive,
	output logic                          cart_rst_out
);

	gb_bus_pkg::region_t cpu_region;
	gb_bus_pkg::region_t dma_region;

	gb_memmap #(.BOOT_OVERLAY(1'b1)) cpu_map (
		.adr(cpu.adr),
		.boot_hidden(boot_hidden),
		.region(cpu_region)
	);

	// the DMA never sees the boot ROM.
	gb_memmap #(.BOOT_OVERLAY(1'b0)) dma_map (
		.adr(dma.src),
		.boot_hidden(1'b1),
		.region(dma_region)
	);

	gb_iomap io_map (
		.adr(cpu.adr),
		.in_io(cpu_region.io),
		.io_sel(io_sel)
	);

	gb_mem_arbiter arbiter (
		.gbclk(gbclk),
		.rst_n(rst_n),
		.reset_done(reset_done),
		.cpu(cpu),
		.dma(dma),
		.ppu(ppu),
		.cpu_region(cpu_region),
		.dma_region(dma_region),
		.vram(vram),
		.oam(oam),
		.ext(ext),
		.ext_oe(ext_oe)
	);

	gb_read_mux read_mux (
		.cpu_region(cpu_region),
		.dma_region(dma_region),
		.io_sel(io_sel),
		.dma(dma),
		.ppu(ppu),
		.rdata(rdata),
		.cpu_rdata(cpu_rdata),
		.dma_rdata(dma_rdata)
	);

	gb_reset_seq #(
		.INIT_TICK_W(INIT_TICK_W),
		.RST_TICK_W(RST_TICK_W)
	) reset_seq (
		.gbclk(gbclk),
		.rst_n(rst_n),
		.gb_on(gb_on),
		.cart_mode(cart_mode),
		.cart_rst_in(cart_rst_in),
		.reset_done(reset_done),
		.reset_gb(reset_gb),
		.cart_rst_drive(cart_rst_drive)
	);

	assign cart_rst_out = !cart_rst_drive;

endmodule

//--- bench/gb_bus_props.sv
`timescale 1ns/1ns

module gb_bus_props (
	input logic                   gbclk,
	input logic                   rst_n,
	input logic                   reset_done,
	input logic                   ext_oe,
	input gb_bus_pkg::ppu_req_t   ppu,
	input gb_bus_pkg::dma_req_t   dma,
	input gb_bus_pkg::region_t    dma_region,
	input gb_bus_pkg::vram_port_t vram,
	input gb_bus_pkg::ext_port_t  ext
);

	logic dma_owns_ext;

	assign dma_owns_ext = dma.active && (dma_region.rom || dma_region.xram || dma_region.wram);

	// the data pins stay off until the system leaves reset.
	oe_after_reset: assert property (@(posedge gbclk) disable iff (!rst_n)
		!(ext_oe && !reset_done))
		else $error("ext_oe is high while reset_done is low");

	vram_ppu_read_only: assert property (@(posedge gbclk) disable iff (!rst_n)
		!(ppu.needs_vram && vram.wr))
		else $error("vram port writes while the PPU holds VRAM");

	ext_dma_read_only: assert property (@(posedge gbclk) disable iff (!rst_n)
		!(dma_owns_ext && ext.wr))
		else $error("external bus writes while the DMA owns it");

endmodule

bind gb_bus_top gb_bus_props props (
	.gbclk(gbclk),
	.rst_n(rst_n),
	.reset_done(reset_done),
	.ext_oe(ext_oe),
	.ppu(ppu),
	.dma(dma),
	.dma_region(dma_region),
	.vram(vram),
	.ext(ext)
);

//--- bench/tb_gb_bus.sv
`timescale 1ns/1ns

module tb_gb_bus;

	localparam int INIT_TICK_W = 4;
	localparam int RST_TICK_W  = 4;
	localparam int INIT_DELAY  = 1 << INIT_TICK_W;
	localparam int RST_PHASE   = 1 << RST_TICK_W;

	logic                          gbclk;
	logic                          rst_n;
	gb_bus_pkg::cpu_req_t          cpu;
	gb_bus_pkg::dma_req_t          dma;
	gb_bus_pkg::ppu_req_t          ppu;
	gb_bus_pkg::periph_rdata_t     rdata;
	logic                          boot_hidden;
	logic                          gb_on;
	logic                          cart_mode;
	logic                          cart_rst_in;
	gb_bus_pkg::vram_port_t        vram;
	gb_bus_pkg::oam_port_t         oam;
	gb_bus_pkg::ext_port_t         ext;
	logic                          ext_oe;
	gb_bus_pkg::io_sel_t           io_sel;
	logic [gb_bus_pkg::DATA_W-1:0] cpu_rdata;
	logic [gb_bus_pkg::DATA_W-1:0] dma_rdata;
	logic                          reset_gb;
	logic                          reset_done;
	logic                          cart_rst_drive;
	logic                          cart_rst_out;

	int                    seed;
	int                    errors;
	int                    checks;
	logic                  check_en;
	logic                  last_ext_wr;
	gb_bus_pkg::ext_port_t exp_ext;

	gb_bus_top #(
		.INIT_TICK_W(INIT_TICK_W),
		.RST_TICK_W(RST_TICK_W)
	) UUT (
		.gbclk(gbclk),
		.rst_n(rst_n),
		.cpu(cpu),
		.dma(dma),
		.ppu(ppu),
		.rdata(rdata),
		.boot_hidden(boot_hidden),
		.gb_on(gb_on),
		.cart_mode(cart_mode),
		.cart_rst_in(cart_rst_in),
		.vram(vram),
		.oam(oam),
		.ext(ext),
		.ext_oe(ext_oe),
		.io_sel(io_sel),
		.cpu_rdata(cpu_rdata),
		.dma_rdata(dma_rdata),
		.reset_gb(reset_gb),
		.reset_done(reset_done),
		.cart_rst_drive(cart_rst_drive),
		.cart_rst_out(cart_rst_out)
	);

	always #5 gbclk = ~gbclk;

	function automatic gb_bus_pkg::region_t expected_region(input logic [15:0] a,
			input logic overlay, input logic hidden);
		gb_bus_pkg::region_t r;
		r = '0;
		if (a <= 16'h00ff && overlay && !hidden)
			r.boot = 1'b1;
		else if (a <= 16'h7fff)
			r.rom = 1'b1;
		else if (a <= 16'h9fff)
			r.vram = 1'b1;
		else if (a <= 16'hbfff)
			r.xram = 1'b1;
		else if (a <= 16'hfdff)
			r.wram = 1'b1;
		else if (a <= 16'hfe9f)
			r.oam = 1'b1;
		else if (a >= 16'hff00)
			r.io = 1'b1;
		return r;
	endfunction

	function automatic gb_bus_pkg::io_sel_t expected_io_sel(input logic [15:0] a);
		gb_bus_pkg::io_sel_t s;
		logic [7:0]          o;
		s = '0;
		o = a[7:0];
		if (a[15:8] == 8'hff) begin
			s.joypad   = o == 8'h00;
			s.serial   = o == 8'h01 || o == 8'h02;
			s.timer    = o >= 8'h04 && o <= 8'h07;
			s.int_flag = o == 8'h0f;
			s.sound    = o >= 8'h10 && o <= 8'h3f;
			s.ppu      = o >= 8'h40 && o <= 8'h4b;
			s.boot_reg = o == 8'h50;
			s.hram     = o >= 8'h80 && o <= 8'hfe;
			s.int_ena  = o == 8'hff;
		end
		return s;
	endfunction

	function automatic gb_bus_pkg::vram_port_t expected_vram(input gb_bus_pkg::cpu_req_t c,
			input gb_bus_pkg::dma_req_t d, input gb_bus_pkg::ppu_req_t p, input logic hidden);
		gb_bus_pkg::vram_port_t v;
		gb_bus_pkg::region_t    cr;
		gb_bus_pkg::region_t    dr;
		v  = '0;
		cr = expected_region(c.adr.full, 1'b1, hidden);
		dr = expected_region(d.src, 1'b0, 1'b1);
		if (p.needs_vram) begin
			v.adr = p.adr[12:0];
			v.rd  = p.rd;
		end else if (d.active && dr.vram) begin
			v.adr = d.src[12:0];
			v.rd  = d.rd;
		end else if (cr.vram) begin
			v.adr   = c.adr.full[12:0];
			v.rd    = c.rd;
			v.wr    = c.wr;
			v.wdata = c.wdata;
		end
		return v;
	endfunction

	function automatic gb_bus_pkg::oam_port_t expected_oam(input gb_bus_pkg::cpu_req_t c,
			input gb_bus_pkg::dma_req_t d, input gb_bus_pkg::ppu_req_t p, input logic hidden);
		gb_bus_pkg::oam_port_t o;
		gb_bus_pkg::region_t   cr;
		o  = '0;
		cr = expected_region(c.adr.full, 1'b1, hidden);
		if (p.needs_oam) begin
			o.adr = p.adr[7:0];
			o.rd  = p.rd;
		end else if (d.active) begin
			o.adr   = d.dst;
			o.wr    = d.wr;
			o.wdata = d.data;
		end else if (cr.oam) begin
			o.adr   = c.adr.full[7:0];
			o.rd    = c.rd;
			o.wr    = c.wr;
			o.wdata = c.wdata;
		end
		return o;
	endfunction

	function automatic gb_bus_pkg::ext_port_t expected_ext(input gb_bus_pkg::cpu_req_t c,
			input gb_bus_pkg::dma_req_t d, input logic hidden);
		gb_bus_pkg::ext_port_t e;
		gb_bus_pkg::region_t   cr;
		gb_bus_pkg::region_t   dr;
		cr = expected_region(c.adr.full, 1'b1, hidden);
		dr = expected_region(d.src, 1'b0, 1'b1);
		e.cs_rom  = cr.rom | dr.rom;
		e.cs_xram = cr.xram | dr.xram;
		e.cs_wram = cr.wram | dr.wram;
		e.wdata   = c.wdata;
		e.adr     = c.adr.full;
		e.rd      = c.rd;
		e.wr      = c.wr;
		if (d.active && (dr.rom || dr.xram || dr.wram)) begin
			e.adr = d.src;
			e.rd  = d.rd;
			e.wr  = 1'b0;
		end
		return e;
	endfunction

	function automatic logic [7:0] expected_cpu_rdata(input gb_bus_pkg::cpu_req_t c,
			input gb_bus_pkg::dma_req_t d, input gb_bus_pkg::ppu_req_t p,
			input gb_bus_pkg::periph_rdata_t rd, input logic hidden);
		gb_bus_pkg::region_t cr;
		gb_bus_pkg::region_t dr;
		gb_bus_pkg::io_sel_t s;
		logic                dma_ext;
		logic [7:0]          v;
		cr      = expected_region(c.adr.full, 1'b1, hidden);
		dr      = expected_region(d.src, 1'b0, 1'b1);
		s       = expected_io_sel(c.adr.full);
		dma_ext = d.active && (dr.rom || dr.xram || dr.wram);
		if (s.hram)
			v = rd.hram;
		else if (s.joypad)
			v = rd.joy;
		else if (s.serial)
			v = rd.sio;
		else if (s.timer)
			v = rd.tim;
		else if (s.sound)
			v = rd.snd;
		else if (s.ppu)
			v = rd.ppu;
		else if (s.int_flag || s.int_ena)
			v = rd.cpureg;
		else if (cr.boot)
			v = rd.brom;
		else if (cr.vram)
			v = (p.needs_vram || (d.active && dr.vram)) ? gb_bus_pkg::OPEN_BUS : rd.vram;
		else if (cr.oam)
			v = (p.needs_oam || d.active) ? gb_bus_pkg::OPEN_BUS : rd.oam;
		else if (cr.rom || cr.xram || cr.wram)
			v = dma_ext ? gb_bus_pkg::OPEN_BUS : rd.ext;
		else
			v = gb_bus_pkg::OPEN_BUS;
		return v;
	endfunction

	function automatic logic [7:0] expected_dma_rdata(input gb_bus_pkg::dma_req_t d,
			input gb_bus_pkg::ppu_req_t p, input gb_bus_pkg::periph_rdata_t rd);
		gb_bus_pkg::region_t dr;
		logic [7:0]          v;
		dr = expected_region(d.src, 1'b0, 1'b1);
		if (dr.vram && !p.needs_vram)
			v = rd.vram;
		else if (dr.rom || dr.xram || dr.wram)
			v = rd.ext;
		else
			v = gb_bus_pkg::OPEN_BUS;
		return v;
	endfunction

	// mostly random words, with extra weight on the small regions.
	function automatic logic [15:0] pick_address(input logic [31:0] r);
		logic [15:0] a;
		case (r[2:0])
			3'd0: a = {8'h00, r[15:8]};
			3'd1: a = {8'hfe, r[15:8]};
			3'd2: a = {8'hff, r[15:8]};
			3'd3: a = {3'b100, r[20:8]};
			default: a = r[31:16];
		endcase
		return a;
	endfunction

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_vram(input gb_bus_pkg::vram_port_t got,
			input gb_bus_pkg::vram_port_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: vram port is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_oam(input gb_bus_pkg::oam_port_t got,
			input gb_bus_pkg::oam_port_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: oam port is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_ext(input gb_bus_pkg::ext_port_t got,
			input gb_bus_pkg::ext_port_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: ext port is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_io(input gb_bus_pkg::io_sel_t got, input gb_bus_pkg::io_sel_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: io_sel is %b, expected %b", $time, got, exp);
		end
	endtask

	// outputs are compared at the falling edge, half a cycle after the inputs settle.
	always @(negedge gbclk) begin
		exp_ext = expected_ext(cpu, dma, boot_hidden);
		if (check_en) begin
			check_vram(vram, expected_vram(cpu, dma, ppu, boot_hidden));
			check_oam(oam, expected_oam(cpu, dma, ppu, boot_hidden));
			check_ext(ext, exp_ext);
			check_io(io_sel, expected_io_sel(cpu.adr.full));
			check_byte("cpu_rdata", cpu_rdata,
				expected_cpu_rdata(cpu, dma, ppu, rdata, boot_hidden));
			check_byte("dma_rdata", dma_rdata, expected_dma_rdata(dma, ppu, rdata));
			check_flag("ext_oe", ext_oe, reset_done && (exp_ext.wr || last_ext_wr));
			if (!cart_mode) begin
				check_flag("cart_rst_drive", cart_rst_drive, 1'b0);
				check_flag("cart_rst_out", cart_rst_out, 1'b1);
			end
			if (gb_on)
				check_flag("reset_gb", reset_gb, !reset_done);
		end
		last_ext_wr = rst_n && exp_ext.wr;
	end

	task automatic next_cycle();
		@(posedge gbclk);
		#1;
	endtask

	task automatic idle_inputs();
		cpu = '0;
		dma = '0;
		ppu = '0;
	endtask

	task automatic finish_test(input string name, input int start);
		$display("test %s: %0d errors", name, errors - start);
	endtask

	task automatic power_up_sequence();
		int start;
		int cycles;
		int limit;
		start  = errors;
		limit  = INIT_DELAY + 2 * RST_PHASE + 4;
		cycles = 0;
		next_cycle();
		gb_on = 1'b1;
		while (!reset_done && cycles < limit) begin
			@(negedge gbclk);
			cycles++;
		end
		if (!reset_done) begin
			errors++;
			$display("timeout: reset_done did not rise within %0d cycles of power on", limit);
		end else if (cycles < 2 * RST_PHASE) begin
			errors++;
			$display("reset_done rose only %0d cycles after power on", cycles);
		end
		finish_test("power-up reset sequence", start);
	endtask

	task automatic random_cpu_access();
		int start;
		int r;
		start = errors;
		for (int i = 0; i < 200; i++) begin
			next_cycle();
			r = $random(seed);
			cpu.adr.full = pick_address(r);
			cpu.wr       = r[3];
			cpu.rd       = !r[3];
			boot_hidden  = r[4];
			r = $random(seed);
			cpu.wdata    = r[7:0];
		end
		next_cycle();
		idle_inputs();
		finish_test("random cpu access", start);
	endtask

	task automatic ppu_contention();
		int start;
		int r;
		start = errors;
		for (int i = 0; i < 40; i++) begin
			next_cycle();
			r = $random(seed);
			ppu.adr        = r[31:16];
			ppu.rd         = 1'b1;
			ppu.needs_vram = r[0];
			ppu.needs_oam  = !r[0];
			cpu.adr.full   = r[1] ? {3'b100, r[12:0]} : {8'hfe, 1'b0, r[6:0]};
			cpu.wr         = r[2];
			cpu.rd         = !r[2];
			cpu.wdata      = r[15:8];
			@(negedge gbclk);
			// r[1] picks vram for the CPU, r[0] picks vram for the PPU.
			if (r[1] == r[0])
				check_byte("contended cpu_rdata", cpu_rdata, gb_bus_pkg::OPEN_BUS);
		end
		next_cycle();
		idle_inputs();
		finish_test("ppu priority", start);
	endtask

	task automatic dma_transfer();
		int start;
		int r;
		start = errors;
		for (int i = 0; i < 60; i++) begin
			next_cycle();
			r = $random(seed);
			dma.active = 1'b1;
			dma.rd     = 1'b1;
			dma.wr     = 1'b1;
			dma.dst    = r[15:8];
			dma.data   = r[7:0];
			case (r[3:2])
				2'd0: dma.src = {1'b0, r[30:16]};
				2'd1: dma.src = {3'b100, r[28:16]};
				2'd2: dma.src = {3'b101, r[28:16]};
				2'd3: dma.src = {3'b110, r[28:16]};
			endcase
			r = $random(seed);
			cpu.adr.full   = pick_address(r);
			cpu.rd         = 1'b1;
			ppu.needs_vram = r[5:4] == 2'b00;
			ppu.rd         = 1'b1;
		end
		next_cycle();
		idle_inputs();
		finish_test("dma transfer", start);
	endtask

	task automatic write_output_enable();
		int start;
		start = errors;
		next_cycle();
		cpu.adr.full = 16'hc123;
		cpu.wr       = 1'b1;
		cpu.wdata    = 8'h5a;
		@(negedge gbclk);
		check_flag("ext_oe during write", ext_oe, 1'b1);
		next_cycle();
		next_cycle();
		cpu.wr = 1'b0;
		cpu.rd = 1'b1;
		@(negedge gbclk);
		check_flag("ext_oe one cycle after write", ext_oe, 1'b1);
		next_cycle();
		@(negedge gbclk);
		check_flag("ext_oe two cycles after write", ext_oe, 1'b0);
		next_cycle();
		idle_inputs();
		finish_test("external output enable", start);
	endtask

	task automatic cart_reset_request();
		int start;
		int cycles;
		int limit;
		start = errors;
		limit = 2 * RST_PHASE + 4;
		next_cycle();
		cart_mode = 1'b1;
		next_cycle();
		@(negedge gbclk);
		check_flag("cart_rst_drive while done", cart_rst_drive, 1'b1);
		check_flag("cart_rst_out while done", cart_rst_out, 1'b0);
		next_cycle();
		cart_rst_in = 1'b0;
		cycles = 0;
		while (reset_done && cycles < 4) begin
			@(negedge gbclk);
			cycles++;
		end
		if (reset_done) begin
			errors++;
			$display("timeout: reset_done stayed high after the cartridge pulled its reset");
		end
		// the pin is released during the assert phase.
		check_flag("cart_rst_drive in assert phase", cart_rst_drive, 1'b0);
		check_flag("cart_rst_out in assert phase", cart_rst_out, 1'b1);
		repeat (2 * RST_PHASE + 8) begin
			@(negedge gbclk);
			check_flag("reset_done while cartridge holds reset", reset_done, 1'b0);
		end
		next_cycle();
		cart_rst_in = 1'b1;
		cycles = 0;
		while (!reset_done && cycles < limit) begin
			@(negedge gbclk);
			cycles++;
		end
		if (!reset_done) begin
			errors++;
			$display("timeout: reset_done did not return within %0d cycles", limit);
		end
		finish_test("cartridge reset", start);
	endtask

	initial begin
		seed        = 42;
		errors      = 0;
		checks      = 0;
		check_en    = 1'b0;
		last_ext_wr = 1'b0;
		gbclk       = 1'b0;
		rst_n       = 1'b0;
		boot_hidden = 1'b0;
		gb_on       = 1'b0;
		cart_mode   = 1'b0;
		cart_rst_in = 1'b1;
		idle_inputs();
		rdata.hram   = 8'h80;
		rdata.joy    = 8'h0a;
		rdata.sio    = 8'h1b;
		rdata.tim    = 8'h2c;
		rdata.snd    = 8'h3d;
		rdata.ppu    = 8'h4e;
		rdata.cpureg = 8'h5f;
		rdata.brom   = 8'h6a;
		rdata.vram   = 8'h7b;
		rdata.oam    = 8'h8c;
		rdata.ext    = 8'h9d;
		repeat (10) @(posedge gbclk);
		#1;
		rst_n    = 1'b1;
		check_en = 1'b1;
		power_up_sequence();
		random_cpu_access();
		ppu_contention();
		dma_transfer();
		write_output_enable();
		cart_reset_request();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- files.f
hw/gb_bus_pkg.sv
hw/gb_memmap.sv
hw/gb_iomap.sv
hw/gb_mem_arbiter.sv
hw/gb_read_mux.sv
hw/gb_reset_seq.sv
hw/gb_bus_top.sv
bench/gb_bus_props.sv
bench/tb_gb_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_gb_bus -f files.f -o tb_gb_bus_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_gb_bus_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
	exit 0
fi
exit 1
